/* verilog/alu_pkg.sv */
`default_nettype none

package alu_pkg;

	localparam int DATA_W  = 32;
	localparam int IMM_W   = 16;
	localparam int SHAMT_W = 5;

	// codes 16 to 31 are not listed and are reported as invalid by the ALU
	typedef enum logic [4:0] {
		ALU_ADD  = 5'd0,
		ALU_SUB  = 5'd1,
		ALU_AND  = 5'd2,
		ALU_OR   = 5'd3,
		ALU_NOT  = 5'd4,
		ALU_XOR  = 5'd5,
		ALU_MOVZ = 5'd6,
		ALU_NOR  = 5'd7,
		ALU_SLT  = 5'd8,
		ALU_SLTU = 5'd9,
		ALU_SLL  = 5'd10,
		ALU_SRL  = 5'd11,
		ALU_SRA  = 5'd12,
		ALU_SLLV = 5'd13,
		ALU_SRLV = 5'd14,
		ALU_SRAV = 5'd15
	} alu_op_t;

	typedef enum logic [1:0] {
		ALU_EQUAL   = 2'd0,
		ALU_SMALLER = 2'd1,
		ALU_LARGER  = 2'd2
	} cmp_t;

	typedef enum logic [1:0] {
		SHIFT_LL = 2'd0,
		SHIFT_RL = 2'd1,
		SHIFT_RA = 2'd2
	} shift_kind_t;

endpackage

`default_nettype wire

/* verilog/alu_shifter.sv */
`default_nettype none

module alu_shifter import alu_pkg::*; (
	input  wire [DATA_W-1:0]  value,
	input  wire [SHAMT_W-1:0] amount,
	input  wire shift_kind_t  kind,
	output logic [DATA_W-1:0] shifted
);

	function automatic logic [DATA_W-1:0] reverse_bits(input logic [DATA_W-1:0] v);
		logic [DATA_W-1:0] r;
		for (int i = 0; i < DATA_W; i++) begin
			r[i] = v[DATA_W-1-i];
		end
		return r;
	endfunction

	logic                  fill;
	logic [DATA_W-1:0] stage [SHAMT_W+1];

	// a left shift runs through the same right-shift barrel on the bit-reversed value
	assign fill     = (kind == SHIFT_RA) ? value[DATA_W-1] : 1'b0;
	assign stage[0] = (kind == SHIFT_LL) ? reverse_bits(value) : value;

	for (genvar s = 0; s < SHAMT_W; s++) begin : g_stage
		assign stage[s+1] = amount[s] ?
			{{(1 << s){fill}}, stage[s][DATA_W-1:(1 << s)]} : stage[s];
	end

	assign shifted = (kind == SHIFT_LL) ? reverse_bits(stage[SHAMT_W]) : stage[SHAMT_W];

endmodule

`default_nettype wire

/* verilog/alu.sv */
`default_nettype none

module alu import alu_pkg::*; (
	input  wire [DATA_W-1:0]  num1,
	input  wire [DATA_W-1:0]  num2,
	input  wire [SHAMT_W-1:0] shamt,
	input  wire alu_op_t      op,
	output logic [DATA_W-1:0] result,
	output cmp_t              cmp_result,
	output cmp_t              sig_cmp_result,
	output logic              overflow,
	output logic              op_invalid
);

	logic [DATA_W:0]    sum;
	logic [DATA_W:0]    diff;
	logic               is_equal;
	logic               uns_less;
	logic               sig_less;
	logic               var_shift;
	logic [SHAMT_W-1:0] shift_amt;
	shift_kind_t        shift_kind;
	logic [DATA_W-1:0]  shifted;

	// 33-bit forms so bit 32 carries the carry or borrow out
	assign sum  = {1'b0, num1} + {1'b0, num2};
	assign diff = {1'b0, num1} - {1'b0, num2};

	assign is_equal = (num1 == num2);
	assign uns_less = (num1 < num2);
	assign sig_less = ($signed(num1) < $signed(num2));

	// variable shifts take their amount from the low bits of rs
	assign var_shift = (op == ALU_SLLV) || (op == ALU_SRLV) || (op == ALU_SRAV);
	assign shift_amt = var_shift ? num1[SHAMT_W-1:0] : shamt;

	always_comb begin
		case (op)
			ALU_SRL, ALU_SRLV: shift_kind = SHIFT_RL;
			ALU_SRA, ALU_SRAV: shift_kind = SHIFT_RA;
			default:           shift_kind = SHIFT_LL;
		endcase
	end

	alu_shifter u_shifter (
		.value   (num2),
		.amount  (shift_amt),
		.kind    (shift_kind),
		.shifted (shifted)
	);

	always_comb begin
		result     = '0;
		op_invalid = 1'b0;
		case (op)
			ALU_ADD:  result = sum[DATA_W-1:0];
			ALU_SUB:  result = diff[DATA_W-1:0];
			ALU_AND:  result = num1 & num2;
			ALU_OR:   result = num1 | num2;
			ALU_NOT:  result = ~num1;
			ALU_XOR:  result = num1 ^ num2;
			ALU_MOVZ: result = num1;
			ALU_NOR:  result = ~(num1 | num2);
			ALU_SLT:  result = {{(DATA_W-1){1'b0}}, sig_less};
			ALU_SLTU: result = {{(DATA_W-1){1'b0}}, uns_less};
			ALU_SLL, ALU_SRL, ALU_SRA,
			ALU_SLLV, ALU_SRLV, ALU_SRAV: begin
				result = shifted;
			end
			default: begin
				op_invalid = 1'b1;
			end
		endcase
	end

	always_comb begin
		case (op)
			ALU_ADD: overflow = sum[DATA_W];
			ALU_SUB: overflow = diff[DATA_W];
			default: overflow = 1'b0;
		endcase
	end

	// compares are valid whatever the op is
	assign cmp_result     = is_equal ? ALU_EQUAL : (uns_less ? ALU_SMALLER : ALU_LARGER);
	assign sig_cmp_result = is_equal ? ALU_EQUAL : (sig_less ? ALU_SMALLER : ALU_LARGER);

endmodule

`default_nettype wire

/* verilog/exec_operand_sel.sv */
`default_nettype none

module exec_operand_sel import alu_pkg::*; (
	input  wire alu_op_t      op,
	input  wire [DATA_W-1:0]  rt_val,
	input  wire [IMM_W-1:0]   imm,
	input  wire               src_imm,
	output logic [DATA_W-1:0] operand_b
);

	logic              zero_ext;
	logic [DATA_W-1:0] imm_zext;
	logic [DATA_W-1:0] imm_sext;

	// logical immediates (andi, ori, xori) are zero-extended
	always_comb begin
		case (op)
			ALU_AND,
			ALU_OR,
			ALU_XOR,
			ALU_NOR: begin
				zero_ext = 1'b1;
			end
			default: begin
				zero_ext = 1'b0;
			end
		endcase
	end

	assign imm_zext = {{(DATA_W-IMM_W){1'b0}}, imm};
	assign imm_sext = {{(DATA_W-IMM_W){imm[IMM_W-1]}}, imm};

	always_comb begin
		if (!src_imm) begin
			operand_b = rt_val;
		end else if (zero_ext) begin
			operand_b = imm_zext;
		end else begin
			operand_b = imm_sext;
		end
	end

endmodule

`default_nettype wire

/* verilog/exec_unit.sv */
`default_nettype none

module exec_unit import alu_pkg::*; (
	input  wire               clk,
	input  wire               rst_n,

	input  wire               in_valid,
	output logic              in_ready,
	input  wire alu_op_t      in_op,
	input  wire [DATA_W-1:0]  in_rs_val,
	input  wire [DATA_W-1:0]  in_rt_val,
	input  wire [IMM_W-1:0]   in_imm,
	input  wire [SHAMT_W-1:0] in_shamt,
	input  wire               in_src_imm,

	output logic              out_valid,
	input  wire               out_ready,
	output logic [DATA_W-1:0] out_result,
	output cmp_t              out_cmp,
	output cmp_t              out_sig_cmp,
	output logic              out_overflow,
	output logic              out_op_invalid
);

	logic [DATA_W-1:0]  operand_b;

	logic               s1_valid;
	alu_op_t            s1_op;
	logic [DATA_W-1:0]  s1_a;
	logic [DATA_W-1:0]  s1_b;
	logic [SHAMT_W-1:0] s1_shamt;

	logic [DATA_W-1:0]  alu_result;
	cmp_t               alu_cmp;
	cmp_t               alu_sig_cmp;
	logic               alu_overflow;
	logic               alu_op_invalid;

	logic               s2_advance;

	exec_operand_sel u_operand_sel (
		.op        (in_op),
		.rt_val    (in_rt_val),
		.imm       (in_imm),
		.src_imm   (in_src_imm),
		.operand_b (operand_b)
	);

	// stage 1 moves into stage 2 whenever stage 2 can take it
	assign s2_advance = !out_valid || out_ready;
	assign in_ready   = !s1_valid || s2_advance;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			s1_valid  <= 1'b0;
			out_valid <= 1'b0;
		end else begin
			if (in_ready) begin
				s1_valid <= in_valid;
			end
			if (s2_advance) begin
				out_valid <= s1_valid;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (in_valid && in_ready) begin
			s1_op    <= in_op;
			s1_a     <= in_rs_val;
			s1_b     <= operand_b;
			s1_shamt <= in_shamt;
		end
	end

	alu u_alu (
		.num1           (s1_a),
		.num2           (s1_b),
		.shamt          (s1_shamt),
		.op             (s1_op),
		.result         (alu_result),
		.cmp_result     (alu_cmp),
		.sig_cmp_result (alu_sig_cmp),
		.overflow       (alu_overflow),
		.op_invalid     (alu_op_invalid)
	);

	always_ff @(posedge clk) begin
		if (s2_advance && s1_valid) begin
			out_result     <= alu_result;
			out_cmp        <= alu_cmp;
			out_sig_cmp    <= alu_sig_cmp;
			out_overflow   <= alu_overflow;
			out_op_invalid <= alu_op_invalid;
		end
	end

endmodule

`default_nettype wire

/* dv/exec_unit_assertions.sv */
`default_nettype none

module exec_unit_assertions import alu_pkg::*; (
	input wire              clk,
	input wire              rst_n,
	input wire              s1_valid,
	input wire              in_valid,
	input wire              in_ready,
	input wire              out_valid,
	input wire              out_ready,
	input wire [DATA_W-1:0] out_result,
	input wire cmp_t        out_cmp,
	input wire cmp_t        out_sig_cmp,
	input wire              out_overflow,
	input wire              out_op_invalid
);

	a_reset_out_valid: assert property (@(posedge clk) !rst_n |-> !out_valid)
		else $error("out_valid high while in reset");

	// a stalled result has to hold until the consumer takes it
	a_stall_stable: assert property (@(posedge clk) disable iff (!rst_n)
		out_valid && !out_ready |=> out_valid && $stable(out_result) && $stable(out_cmp)
			&& $stable(out_sig_cmp) && $stable(out_overflow) && $stable(out_op_invalid))
		else $error("output payload changed during a stall");

	// stage 1 left unloaded on an edge is empty afterwards and takes new work
	a_ready_when_empty: assert property (@(posedge clk) disable iff (!rst_n)
		in_ready && !in_valid |=> !s1_valid && in_ready)
		else $error("stage 1 did not empty or in_ready stayed low after an idle edge");

endmodule

bind exec_unit exec_unit_assertions u_assertions (
	.clk            (clk),
	.rst_n          (rst_n),
	.s1_valid       (s1_valid),
	.in_valid       (in_valid),
	.in_ready       (in_ready),
	.out_valid      (out_valid),
	.out_ready      (out_ready),
	.out_result     (out_result),
	.out_cmp        (out_cmp),
	.out_sig_cmp    (out_sig_cmp),
	.out_overflow   (out_overflow),
	.out_op_invalid (out_op_invalid)
);

`default_nettype wire

/* dv/tb_exec_unit.sv */
`default_nettype none

module tb_exec_unit import alu_pkg::*; ();

	localparam int NUM_VEC    = 33;
	localparam int FIELDS     = 11;
	localparam int MAX_CYCLES = 4 * NUM_VEC + 50;

	logic               clk;
	logic               rst_n;
	logic               in_valid;
	logic               in_ready;
	alu_op_t            in_op;
	logic [DATA_W-1:0]  in_rs_val;
	logic [DATA_W-1:0]  in_rt_val;
	logic [IMM_W-1:0]   in_imm;
	logic [SHAMT_W-1:0] in_shamt;
	logic               in_src_imm;
	logic               out_valid;
	logic               out_ready;
	logic [DATA_W-1:0]  out_result;
	cmp_t               out_cmp;
	cmp_t               out_sig_cmp;
	logic               out_overflow;
	logic               out_op_invalid;

	// each vector takes FIELDS consecutive words, in the column order of the data file
	logic [DATA_W-1:0] vec_mem [NUM_VEC*FIELDS];
	int                exp_q [$];
	int                cur_idx;
	int                num_checked = 0;
	int                cycle_count = 0;
	integer            seed;

	exec_unit u_exec_unit (
		.clk            (clk),
		.rst_n          (rst_n),
		.in_valid       (in_valid),
		.in_ready       (in_ready),
		.in_op          (in_op),
		.in_rs_val      (in_rs_val),
		.in_rt_val      (in_rt_val),
		.in_imm         (in_imm),
		.in_shamt       (in_shamt),
		.in_src_imm     (in_src_imm),
		.out_valid      (out_valid),
		.out_ready      (out_ready),
		.out_result     (out_result),
		.out_cmp        (out_cmp),
		.out_sig_cmp    (out_sig_cmp),
		.out_overflow   (out_overflow),
		.out_op_invalid (out_op_invalid)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#4 clk = ~clk;
		end
	end

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("TB FAILED");
		$fatal(1, "simulation stopped on error");
	endtask

	task automatic check_word(input string field, input logic [DATA_W-1:0] got,
			input logic [DATA_W-1:0] exp);
		if (got !== exp) begin
			abort_run($sformatf("mismatch at %0t: %s got %08h expected %08h",
				$time, field, got, exp));
		end
	endtask

	task automatic check_cmp(input string field, input cmp_t got, input cmp_t exp);
		if (got !== exp) begin
			abort_run($sformatf("mismatch at %0t: %s got %s expected %s",
				$time, field, got.name(), exp.name()));
		end
	endtask

	task automatic check_flag(input string field, input logic got, input logic exp);
		if (got !== exp) begin
			abort_run($sformatf("mismatch at %0t: %s got %b expected %b",
				$time, field, got, exp));
		end
	endtask

	task automatic apply_vector(input int idx);
		int base;
		base       = idx * FIELDS;
		cur_idx    = idx;
		in_valid   = 1'b1;
		in_op      = alu_op_t'(vec_mem[base][4:0]);
		in_rs_val  = vec_mem[base+1];
		in_rt_val  = vec_mem[base+2];
		in_imm     = vec_mem[base+3][IMM_W-1:0];
		in_shamt   = vec_mem[base+4][SHAMT_W-1:0];
		in_src_imm = vec_mem[base+5][0];
	endtask

	task automatic wait_accept();
		@(posedge clk);
		while (!in_ready) begin
			@(posedge clk);
		end
	endtask

	task automatic end_run();
		if (exp_q.size() != 0) begin
			abort_run("operations still pending after the last expected result");
		end else begin
			$display("TB PASSED");
			$finish;
		end
	endtask

	task automatic check_output();
		int idx;
		int base;
		if (exp_q.size() == 0) begin
			abort_run("output transfer with no operation pending");
		end else begin
			idx  = exp_q.pop_front();
			base = idx * FIELDS;
			check_word($sformatf("vector %0d result", idx), out_result, vec_mem[base+6]);
			check_cmp($sformatf("vector %0d cmp", idx), out_cmp,
				cmp_t'(vec_mem[base+7][1:0]));
			check_cmp($sformatf("vector %0d sig_cmp", idx), out_sig_cmp,
				cmp_t'(vec_mem[base+8][1:0]));
			check_flag($sformatf("vector %0d overflow", idx), out_overflow, vec_mem[base+9][0]);
			check_flag($sformatf("vector %0d op_invalid", idx), out_op_invalid,
				vec_mem[base+10][0]);
			num_checked++;
		end
	endtask

	// driver presents the vectors in file order and holds each one until it is taken
	initial begin
		rst_n      = 1'b1;
		in_valid   = 1'b0;
		in_op      = ALU_ADD;
		in_rs_val  = '0;
		in_rt_val  = '0;
		in_imm     = '0;
		in_shamt   = '0;
		in_src_imm = 1'b0;
		cur_idx    = 0;
		$readmemh("dv/exec_input.txt", vec_mem);
		#1 rst_n = 1'b0;
		repeat (8) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		for (int i = 0; i < NUM_VEC; i++) begin
			@(negedge clk);
			apply_vector(i);
			wait_accept();
		end
		@(negedge clk);
		in_valid = 1'b0;
	end

	initial begin
		seed      = 48393;
		out_ready = 1'b0;
		@(negedge rst_n);
		@(posedge rst_n);
		forever begin
			@(negedge clk);
			// out_ready is low about 30% of the time
			out_ready = ({$random(seed)} % 10) >= 3;
		end
	end

	always @(posedge clk) begin
		if (rst_n) begin
			if (out_valid && out_ready) begin
				check_output();
			end
			if (in_valid && in_ready) begin
				exp_q.push_back(cur_idx);
			end
			if (num_checked == NUM_VEC) begin
				end_run();
			end
		end
	end

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count >= MAX_CYCLES) begin
			abort_run($sformatf("timeout after %0d cycles with %0d of %0d vectors checked",
				cycle_count, num_checked, NUM_VEC));
		end
	end

endmodule

`default_nettype wire

/* dv/exec_input.txt */
// op rs_val rt_val imm shamt src_imm | expected: result cmp sig_cmp overflow op_invalid
// cmp codes are 0 equal, 1 smaller, 2 larger, for rs against the selected operand b
00 00000005 00000003 0000 00 0 00000008 2 2 0 0
00 ffffffff 00000001 0000 00 0 00000000 2 1 1 0
01 00000010 00000003 0000 00 0 0000000d 2 2 0 0
01 00000003 00000005 0000 00 0 fffffffe 1 1 1 0
02 f0f0f0f0 ff00ff00 0000 00 0 f000f000 1 1 0 0
03 12340000 00005678 0000 00 0 12345678 2 2 0 0
04 0000ffff 00000000 0000 00 0 ffff0000 2 2 0 0
05 aaaaaaaa 55555555 0000 00 0 ffffffff 2 1 0 0
06 deadbeef deadbeef 0000 00 0 deadbeef 0 0 0 0
07 0f0f0f0f f0f0f000 0000 00 0 000000f0 1 2 0 0
0a 00000000 00000001 0000 00 0 00000001 1 1 0 0
0a 00000000 00000001 0000 1f 0 80000000 1 1 0 0
0b 00000000 80000000 0000 01 0 40000000 1 2 0 0
0b 00000000 f0000000 0000 1f 0 00000001 1 2 0 0
0c 00000000 80000000 0000 04 0 f8000000 1 2 0 0
0c 00000000 7ffffff0 0000 10 0 00007fff 1 1 0 0
0c 00000000 f0000000 0000 1f 0 ffffffff 1 2 0 0
0d 00000024 0000000f 0000 1f 0 000000f0 2 2 0 0
0e ffffffe8 12345678 0000 03 0 00123456 2 1 0 0
0f 0000003c 80000000 0000 00 0 fffffff8 1 2 0 0
0d 00000000 cafef00d 0000 07 0 cafef00d 1 2 0 0
08 ffffffff 00000001 0000 00 0 00000001 2 1 0 0
09 ffffffff 00000001 0000 00 0 00000000 2 1 0 0
08 7fffffff 80000000 0000 00 0 00000000 1 2 0 0
09 7fffffff 80000000 0000 00 0 00000001 1 2 0 0
08 00000042 00000042 0000 00 0 00000000 0 0 0 0
02 ffffffff 12345678 8000 00 1 00008000 2 1 0 0
03 00000000 00000000 ffff 00 1 0000ffff 1 1 0 0
00 00000010 00000000 ffff 00 1 0000000f 1 2 1 0
08 fffffff0 00000000 fff8 00 1 00000001 1 1 0 0
10 00000001 00000002 0000 00 0 00000000 1 1 0 1
00 00000100 00000200 0000 00 0 00000300 1 1 0 0
1f 00000009 00000009 0000 00 0 00000000 0 0 0 1

/* mips_exec.f */
verilog/alu_pkg.sv
verilog/alu_shifter.sv
verilog/alu.sv
verilog/exec_operand_sel.sv
verilog/exec_unit.sv
dv/exec_unit_assertions.sv
dv/tb_exec_unit.sv

/* run_sim.sh */
#!/usr/bin/env bash
# builds the exec unit testbench with Verilator, runs it and scans the log
set -u

cd "$(dirname "$0")" || exit 1

log_file=sim.log

verilator --binary --timing --assert -j 0 --top-module tb_exec_unit \
	-f mips_exec.f --Mdir obj_dir -o tb_exec_unit
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/tb_exec_unit > "$log_file" 2>&1
sim_status=$?
cat "$log_file"

if grep -q "TB FAILED" "$log_file"; then
	exit 1
fi
if [ $sim_status -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi
exit 0
